// ==== run_sim.sh ====
#!/bin/sh
# build and run the gb_mmio testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f verilog.f --top-module tb_gb_mmio -o tb_gb_mmio

./obj_dir/tb_gb_mmio > sim.log 2>&1 || true
cat sim.log

if grep -qx "sim passed" sim.log; then
   exit 0
else
   echo "simulation did not pass, see sim.log"
   exit 1
fi

// ==== source/axi_lite_host_port.sv ====
//**************************************************************************
// AXI4-Lite host port
// serves one read or write at a time as a single-byte bus request
//**************************************************************************
`timescale 1ns/100ps
`include "gb_defines.svh"

module axi_lite_host_port (
   input  logic                  clock,
   input  logic                  reset,
   input  logic                  awvalid,
   output logic                  awready,
   input  logic [`GB_ADDR_W-1:0] awaddr,
   input  logic                  wvalid,
   output logic                  wready,
   input  logic [31:0]           wdata,
   input  logic [3:0]            wstrb,
   output logic                  bvalid,
   input  logic                  bready,
   output logic [1:0]            bresp,
   input  logic                  arvalid,
   output logic                  arready,
   input  logic [`GB_ADDR_W-1:0] araddr,
   output logic                  rvalid,
   input  logic                  rready,
   output logic [31:0]           rdata,
   output logic [1:0]            rresp,
   output logic                  host_req,
   output logic                  host_we,
   output gb_bus_pkg::bus_addr_u host_addr,
   output logic [`GB_DATA_W-1:0] host_wdata,
   input  logic                  host_gnt,
   input  logic [`GB_DATA_W-1:0] bus_rdata
);
   import gb_bus_pkg::*;

   localparam logic [1:0] st_idle   = 2'd0;
   localparam logic [1:0] st_access = 2'd1;
   localparam logic [1:0] st_resp   = 2'd2;

   logic [1:0]            state;
   logic                  is_write;
   logic                  rd_pending;
   logic                  rd_accept;
   logic                  wr_accept;
   logic [`GB_DATA_W-1:0] rdata_q;

   // a waiting read wins over a write
   assign rd_accept = (state == st_idle) && arvalid;
   assign wr_accept = (state == st_idle) && !arvalid && awvalid && wvalid;
   assign arready   = rd_accept;
   assign awready   = wr_accept;
   assign wready    = wr_accept;

   assign host_req = (state == st_access) && !rd_pending;
   assign bvalid   = (state == st_resp) && is_write;
   assign rvalid   = (state == st_resp) && !is_write;
   assign rdata    = {{(32 - `GB_DATA_W){1'b0}}, rdata_q};
   assign bresp    = 2'b00;
   assign rresp    = 2'b00;

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         state      <= st_idle;
         is_write   <= 1'b0;
         rd_pending <= 1'b0;
         host_we    <= 1'b0;
      end else begin
         case (state)
            st_idle: begin
               if (rd_accept || wr_accept) begin
                  state    <= st_access;
                  is_write <= wr_accept;
                  // lane 0 off means a harmless read instead of a write
                  host_we  <= wr_accept && wstrb[0];
               end
            end
            st_access: begin
               if (rd_pending) begin
                  rd_pending <= 1'b0;
                  state      <= st_resp;
               end else if (host_gnt) begin
                  rd_pending <= !is_write;
                  if (is_write) begin
                     state <= st_resp;
                  end
               end
            end
            default: begin
               if ((bvalid && bready) || (rvalid && rready)) begin
                  state <= st_idle;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clock) begin
      if (rd_accept) begin
         host_addr.full <= araddr;
      end else if (wr_accept) begin
         host_addr.full <= awaddr;
         host_wdata     <= wdata[`GB_DATA_W-1:0];
      end
      if (rd_pending) begin
         rdata_q <= bus_rdata;
      end
   end

   // request held steady until the arbiter takes it
   a_req_stable: assert property (@(posedge clock) disable iff (reset)
      host_req && !host_gnt |=> host_req && $stable(host_addr));

endmodule

// ==== source/bus_arbiter.sv ====
//**************************************************************************
// system bus arbiter
// grants DMA or host, decodes the address, holds IF and IE, muxes rdata
//**************************************************************************
`timescale 1ns/100ps
`include "gb_defines.svh"

module bus_arbiter (
   input  logic                  clock,
   input  logic                  reset,
   input  logic                  host_req,
   input  logic                  host_we,
   input  gb_bus_pkg::bus_addr_u host_addr,
   input  logic [`GB_DATA_W-1:0] host_wdata,
   output logic                  host_gnt,
   input  logic                  dma_req,
   input  logic                  dma_we,
   input  gb_bus_pkg::bus_addr_u dma_addr,
   input  logic [`GB_DATA_W-1:0] dma_wdata,
   output logic                  dma_gnt,
   output logic [`GB_DATA_W-1:0] rdata,
   output gb_bus_pkg::region_e   sel,
   output logic                  we,
   output gb_bus_pkg::bus_addr_u addr,
   output logic [`GB_DATA_W-1:0] wdata,
   input  logic [`GB_DATA_W-1:0] wram_oam_rdata,
   input  logic [`GB_DATA_W-1:0] timer_rdata,
   input  logic                  timer_irq,
   output logic                  dma_start,
   output logic [7:0]            dma_page,
   input  logic                  dma_busy,
   output logic                  irq
);
   import gb_bus_pkg::*;

   master_e               owner;
   logic                  active;
   region_e               region;
   region_e               sel_q;
   logic [`GB_IRQ_W-1:0]  if_q;
   logic [`GB_IRQ_W-1:0]  ie_q;
   logic [`GB_DATA_W-1:0] local_rdata;

   // DMA first, and the host stays out for a whole transfer
   always_comb begin
      owner  = dma_req ? dma : host;
      active = dma_req || (host_req && !dma_busy && !dma_start);
   end

   assign dma_gnt  = active && (owner == dma);
   assign host_gnt = active && (owner == host);
   assign addr     = (owner == dma) ? dma_addr : host_addr;
   assign wdata    = (owner == dma) ? dma_wdata : host_wdata;
   assign we       = active && ((owner == dma) ? dma_we : host_we);
   assign sel      = active ? region : unmapped;

   always_comb begin
      if (addr.full >= `GB_WRAM_START && addr.full <= `GB_WRAM_END) begin
         region = wram;
      end else if (addr.full >= `GB_OAM_START && addr.full <= `GB_OAM_END) begin
         region = oam;
      end else if (addr.full >= `GB_MMIO_DIV && addr.full <= `GB_MMIO_TAC) begin
         region = timer;
      end else if (addr.full == `GB_MMIO_IF || addr.full == `GB_MMIO_IE) begin
         region = intr;
      end else if (addr.full == `GB_MMIO_DMA) begin
         region = dma_reg;
      end else begin
         region = unmapped;
      end
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         sel_q       <= unmapped;
         if_q        <= '0;
         ie_q        <= '0;
         dma_start   <= 1'b0;
         dma_page    <= '0;
         local_rdata <= '0;
      end else begin
         sel_q     <= sel;
         dma_start <= we && (sel == dma_reg);
         if (we && sel == dma_reg) begin
            dma_page <= wdata;
         end
         if (we && sel == intr && addr.full == `GB_MMIO_IE) begin
            ie_q <= wdata[`GB_IRQ_W-1:0];
         end
         if (we && sel == intr && addr.full == `GB_MMIO_IF) begin
            if_q <= wdata[`GB_IRQ_W-1:0];
         end
         // timer pulse beats a same-cycle software clear
         if (timer_irq) begin
            if_q[`GB_IRQ_TIMER] <= 1'b1;
         end
         if (sel == intr) begin
            local_rdata <= {{(`GB_DATA_W - `GB_IRQ_W){1'b0}},
                            (addr.full == `GB_MMIO_IE) ? ie_q : if_q};
         end else if (sel == dma_reg) begin
            local_rdata <= dma_page;
         end
      end
   end

   // read byte one cycle after the grant
   always_comb begin
      case (sel_q)
         wram, oam:     rdata = wram_oam_rdata;
         timer:         rdata = timer_rdata;
         intr, dma_reg: rdata = local_rdata;
         default:       rdata = '0;
      endcase
   end

   assign irq = |(if_q & ie_q);

   // DMA writes land only in OAM
   a_dma_to_oam: assert property (@(posedge clock) disable iff (reset)
      dma_gnt && dma_we |-> region == oam);

endmodule

// ==== source/bus_memories.sv ====
//**************************************************************************
// work RAM and OAM
// synchronous byte arrays, read data one cycle after the access
//**************************************************************************
`timescale 1ns/100ps
`include "gb_defines.svh"

module bus_memories (
   input  logic                  clock,
   input  gb_bus_pkg::region_e   sel,
   input  logic                  we,
   input  gb_bus_pkg::bus_addr_u addr,
   input  logic [`GB_DATA_W-1:0] wdata,
   output logic [`GB_DATA_W-1:0] wram_oam_rdata
);
   import gb_bus_pkg::*;

   logic [`GB_DATA_W-1:0] wram_mem [0:(1 << `GB_WRAM_AW)-1];
   logic [`GB_DATA_W-1:0] oam_mem [0:`GB_OAM_END-`GB_OAM_START];
   logic [`GB_ADDR_W-1:0] wram_off;

   assign wram_off = addr.full - `GB_WRAM_START;

   // OAM sits on a page boundary, so the low byte is the index
   always_ff @(posedge clock) begin
      if (sel == wram) begin
         if (we) begin
            wram_mem[wram_off[`GB_WRAM_AW-1:0]] <= wdata;
         end
         wram_oam_rdata <= wram_mem[wram_off[`GB_WRAM_AW-1:0]];
      end else if (sel == oam) begin
         if (we) begin
            oam_mem[addr.split.offset] <= wdata;
         end
         wram_oam_rdata <= oam_mem[addr.split.offset];
      end
   end

endmodule

// ==== source/gb_bus_pkg.sv ====
//**************************************************************************
// gb system bus types
// address views, decoded regions and bus owners
//**************************************************************************
`include "gb_defines.svh"

package gb_bus_pkg;

   // one bus address, seen whole by the decoder or split by the DMA engine
   typedef union packed {
      logic [`GB_ADDR_W-1:0] full;
      struct packed {
         logic [7:0] page;
         logic [7:0] offset;
      } split;
   } bus_addr_u;

   // address regions from the decoder
   typedef enum logic [2:0] {
      wram,
      oam,
      timer,
      intr,
      dma_reg,
      unmapped
   } region_e;

   // current bus owner
   typedef enum logic {
      host,
      dma
   } master_e;

endpackage

// ==== source/gb_defines.svh ====
//**************************************************************************
// gb system bus definitions
// memory map, register addresses, widths, DMA length and timer rates
//**************************************************************************
`ifndef GB_DEFINES_SVH
`define GB_DEFINES_SVH

// bus widths
`define GB_ADDR_W 16
`define GB_DATA_W 8

// work RAM, 8 KB
`define GB_WRAM_START 16'hC000
`define GB_WRAM_END   16'hDFFF
`define GB_WRAM_AW    13

// object attribute memory
`define GB_OAM_START 16'hFE00
`define GB_OAM_END   16'hFE9F

// memory mapped registers
`define GB_MMIO_DIV  16'hFF04
`define GB_MMIO_TIMA 16'hFF05
`define GB_MMIO_TMA  16'hFF06
`define GB_MMIO_TAC  16'hFF07
`define GB_MMIO_IF   16'hFF0F
`define GB_MMIO_IE   16'hFFFF
`define GB_MMIO_DMA  16'hFF46

// bytes per OAM DMA transfer
`define GB_DMA_LEN 160

// timer divider and clocks per TIMA tick, indexed by TAC[1:0]
`define GB_TIMER_DIV_W 16
`define GB_TAC_RATE0   1024
`define GB_TAC_RATE1   16
`define GB_TAC_RATE2   64
`define GB_TAC_RATE3   256

// interrupt flags
`define GB_IRQ_W     5
`define GB_IRQ_TIMER 2

`endif

// ==== source/gb_mmio.sv ====
//**************************************************************************
// gb memory mapped system bus
// AXI4-Lite host port and OAM DMA share work RAM, OAM, timer and
// interrupt registers through one arbiter
//**************************************************************************
`timescale 1ns/100ps
`include "gb_defines.svh"

module gb_mmio (
   input  logic                  clock,
   input  logic                  reset,
   input  logic                  awvalid,
   output logic                  awready,
   input  logic [`GB_ADDR_W-1:0] awaddr,
   input  logic                  wvalid,
   output logic                  wready,
   input  logic [31:0]           wdata,
   input  logic [3:0]            wstrb,
   output logic                  bvalid,
   input  logic                  bready,
   output logic [1:0]            bresp,
   input  logic                  arvalid,
   output logic                  arready,
   input  logic [`GB_ADDR_W-1:0] araddr,
   output logic                  rvalid,
   input  logic                  rready,
   output logic [31:0]           rdata,
   output logic [1:0]            rresp,
   output logic                  irq
);
   import gb_bus_pkg::*;

   logic                  host_req;
   logic                  host_we;
   bus_addr_u             host_addr;
   logic [`GB_DATA_W-1:0] host_wdata;
   logic                  host_gnt;
   logic                  dma_req;
   logic                  dma_we;
   bus_addr_u             dma_addr;
   logic [`GB_DATA_W-1:0] dma_wdata;
   logic                  dma_gnt;
   logic [`GB_DATA_W-1:0] bus_rdata;
   region_e               sel;
   logic                  bus_we;
   bus_addr_u             bus_addr;
   logic [`GB_DATA_W-1:0] bus_wdata;
   logic [`GB_DATA_W-1:0] wram_oam_rdata;
   logic [`GB_DATA_W-1:0] timer_rdata;
   logic                  timer_irq;
   logic                  dma_start;
   logic [7:0]            dma_page;
   logic                  dma_busy;

   axi_lite_host_port u_host_port (
      .clock      (clock),
      .reset      (reset),
      .awvalid    (awvalid),
      .awready    (awready),
      .awaddr     (awaddr),
      .wvalid     (wvalid),
      .wready     (wready),
      .wdata      (wdata),
      .wstrb      (wstrb),
      .bvalid     (bvalid),
      .bready     (bready),
      .bresp      (bresp),
      .arvalid    (arvalid),
      .arready    (arready),
      .araddr     (araddr),
      .rvalid     (rvalid),
      .rready     (rready),
      .rdata      (rdata),
      .rresp      (rresp),
      .host_req   (host_req),
      .host_we    (host_we),
      .host_addr  (host_addr),
      .host_wdata (host_wdata),
      .host_gnt   (host_gnt),
      .bus_rdata  (bus_rdata)
   );

   bus_arbiter u_bus_arbiter (
      .clock          (clock),
      .reset          (reset),
      .host_req       (host_req),
      .host_we        (host_we),
      .host_addr      (host_addr),
      .host_wdata     (host_wdata),
      .host_gnt       (host_gnt),
      .dma_req        (dma_req),
      .dma_we         (dma_we),
      .dma_addr       (dma_addr),
      .dma_wdata      (dma_wdata),
      .dma_gnt        (dma_gnt),
      .rdata          (bus_rdata),
      .sel            (sel),
      .we             (bus_we),
      .addr           (bus_addr),
      .wdata          (bus_wdata),
      .wram_oam_rdata (wram_oam_rdata),
      .timer_rdata    (timer_rdata),
      .timer_irq      (timer_irq),
      .dma_start      (dma_start),
      .dma_page       (dma_page),
      .dma_busy       (dma_busy),
      .irq            (irq)
   );

   oam_dma u_oam_dma (
      .clock     (clock),
      .reset     (reset),
      .dma_start (dma_start),
      .dma_page  (dma_page),
      .dma_req   (dma_req),
      .dma_we    (dma_we),
      .dma_addr  (dma_addr),
      .dma_wdata (dma_wdata),
      .dma_gnt   (dma_gnt),
      .rdata     (bus_rdata),
      .dma_busy  (dma_busy)
   );

   timer_unit u_timer_unit (
      .clock       (clock),
      .reset       (reset),
      .sel         (sel),
      .we          (bus_we),
      .addr        (bus_addr),
      .wdata       (bus_wdata),
      .timer_rdata (timer_rdata),
      .timer_irq   (timer_irq)
   );

   bus_memories u_bus_memories (
      .clock          (clock),
      .sel            (sel),
      .we             (bus_we),
      .addr           (bus_addr),
      .wdata          (bus_wdata),
      .wram_oam_rdata (wram_oam_rdata)
   );

endmodule

// ==== source/oam_dma.sv ====
//**************************************************************************
// OAM DMA engine
// copies 160 bytes from page:00 into FE00, one read and one write per byte
//**************************************************************************
`timescale 1ns/100ps
`include "gb_defines.svh"

module oam_dma (
   input  logic                  clock,
   input  logic                  reset,
   input  logic                  dma_start,
   input  logic [7:0]            dma_page,
   output logic                  dma_req,
   output logic                  dma_we,
   output gb_bus_pkg::bus_addr_u dma_addr,
   output logic [`GB_DATA_W-1:0] dma_wdata,
   input  logic                  dma_gnt,
   input  logic [`GB_DATA_W-1:0] rdata,
   output logic                  dma_busy
);
   import gb_bus_pkg::*;

   localparam logic [1:0] st_idle  = 2'd0;
   localparam logic [1:0] st_read  = 2'd1;
   localparam logic [1:0] st_latch = 2'd2;
   localparam logic [1:0] st_write = 2'd3;

   logic [1:0]            state;
   logic [7:0]            index;
   logic [7:0]            src_page;
   logic [`GB_DATA_W-1:0] data_q;

   assign dma_req   = (state == st_read) || (state == st_write);
   assign dma_we    = (state == st_write);
   assign dma_wdata = data_q;
   assign dma_busy  = (state != st_idle);

   always_comb begin
      dma_addr.split.page   = (state == st_write) ? 8'(`GB_OAM_START >> 8) : src_page;
      dma_addr.split.offset = index;
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         state    <= st_idle;
         index    <= '0;
         src_page <= '0;
      end else begin
         case (state)
            st_idle: begin
               if (dma_start) begin
                  state    <= st_read;
                  index    <= '0;
                  src_page <= dma_page;
               end
            end
            st_read: begin
               if (dma_gnt) begin
                  state <= st_latch;
               end
            end
            // read byte shows up here
            st_latch: state <= st_write;
            default: begin
               if (dma_gnt) begin
                  if (index == 8'(`GB_DMA_LEN - 1)) begin
                     state <= st_idle;
                  end else begin
                     index <= index + 8'd1;
                     state <= st_read;
                  end
               end
            end
         endcase
      end
   end

   always_ff @(posedge clock) begin
      if (state == st_latch) begin
         data_q <= rdata;
      end
   end

   a_index_range: assert property (@(posedge clock) disable iff (reset)
      dma_busy |-> index < 8'(`GB_DMA_LEN));

endmodule

// ==== source/timer_unit.sv ====
//**************************************************************************
// timer registers
// DIV, TIMA, TMA and TAC with reload on overflow and a timer interrupt
//**************************************************************************
`timescale 1ns/100ps
`include "gb_defines.svh"

module timer_unit (
   input  logic                  clock,
   input  logic                  reset,
   input  gb_bus_pkg::region_e   sel,
   input  logic                  we,
   input  gb_bus_pkg::bus_addr_u addr,
   input  logic [`GB_DATA_W-1:0] wdata,
   output logic [`GB_DATA_W-1:0] timer_rdata,
   output logic                  timer_irq
);
   import gb_bus_pkg::*;

   logic [`GB_TIMER_DIV_W-1:0] div_cnt;
   logic [`GB_TIMER_DIV_W-1:0] rate_mask;
   logic [7:0]                 tima;
   logic [7:0]                 tma;
   logic [2:0]                 tac;
   logic                       wr_en;
   logic                       tick;

   assign wr_en = (sel == timer) && we;

   // one tick each time the low divider bits wrap
   always_comb begin
      case (tac[1:0])
         2'd0:    rate_mask = `GB_TIMER_DIV_W'(`GB_TAC_RATE0 - 1);
         2'd1:    rate_mask = `GB_TIMER_DIV_W'(`GB_TAC_RATE1 - 1);
         2'd2:    rate_mask = `GB_TIMER_DIV_W'(`GB_TAC_RATE2 - 1);
         default: rate_mask = `GB_TIMER_DIV_W'(`GB_TAC_RATE3 - 1);
      endcase
   end

   assign tick = tac[2] && ((div_cnt & rate_mask) == rate_mask);

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         div_cnt   <= '0;
         tima      <= '0;
         tma       <= '0;
         tac       <= '0;
         timer_irq <= 1'b0;
      end else begin
         timer_irq <= 1'b0;
         if (wr_en && addr.full == `GB_MMIO_DIV) begin
            div_cnt <= '0;
         end else begin
            div_cnt <= div_cnt + 1'b1;
         end
         if (wr_en && addr.full == `GB_MMIO_TMA) begin
            tma <= wdata;
         end
         if (wr_en && addr.full == `GB_MMIO_TAC) begin
            tac <= wdata[2:0];
         end
         if (wr_en && addr.full == `GB_MMIO_TIMA) begin
            tima <= wdata;
         end else if (tick) begin
            if (tima == 8'hff) begin
               tima      <= tma;
               timer_irq <= 1'b1;
            end else begin
               tima <= tima + 8'd1;
            end
         end
      end
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         timer_rdata <= '0;
      end else if (sel == timer) begin
         case (addr.full)
            `GB_MMIO_DIV:  timer_rdata <= div_cnt[`GB_TIMER_DIV_W-1 -: 8];
            `GB_MMIO_TIMA: timer_rdata <= tima;
            `GB_MMIO_TMA:  timer_rdata <= tma;
            default:       timer_rdata <= {5'b0, tac};
         endcase
      end
   end

endmodule

// ==== testbench/tb_gb_mmio.sv ====
//**************************************************************************
// gb_mmio testbench
// table of AXI4-Lite writes, reads and polls with expected bytes, covering
// work RAM, unmapped reads, OAM DMA, timer registers and the timer interrupt
//**************************************************************************
`timescale 1ns/100ps
`include "gb_defines.svh"

module tb_gb_mmio;

   localparam int op_write    = 0;
   localparam int op_read     = 1;
   localparam int op_read_min = 2;
   localparam int op_poll     = 3;
   localparam int op_irq      = 4;

   logic        clock;
   logic        reset;
   logic        awvalid;
   logic        awready;
   logic [15:0] awaddr;
   logic        wvalid;
   logic        wready;
   logic [31:0] wdata;
   logic [3:0]  wstrb;
   logic        bvalid;
   logic        bready;
   logic [1:0]  bresp;
   logic        arvalid;
   logic        arready;
   logic [15:0] araddr;
   logic        rvalid;
   logic        rready;
   logic [31:0] rdata;
   logic [1:0]  rresp;
   logic        irq;

   // test table, one entry per index
   string       t_name[$];
   int          t_op[$];
   logic [15:0] t_addr[$];
   logic [7:0]  t_wdata[$];
   logic [7:0]  t_exp[$];

   integer seed;
   int     error_count = 0;
   int     check_count = 0;
   int     cycles      = 0;
   int     cycle_limit = 0;

   gb_mmio u_gb_mmio (
      .clock   (clock),
      .reset   (reset),
      .awvalid (awvalid),
      .awready (awready),
      .awaddr  (awaddr),
      .wvalid  (wvalid),
      .wready  (wready),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .bvalid  (bvalid),
      .bready  (bready),
      .bresp   (bresp),
      .arvalid (arvalid),
      .arready (arready),
      .araddr  (araddr),
      .rvalid  (rvalid),
      .rready  (rready),
      .rdata   (rdata),
      .rresp   (rresp),
      .irq     (irq)
   );

   always #5 clock = ~clock;

   // watchdog
   always @(posedge clock) begin
      cycles <= cycles + 1;
      if (cycle_limit > 0 && cycles >= cycle_limit) begin
         $display("timeout: run stopped after %0d cycles", cycles);
         $display("errors: %0d of %0d checks", error_count, check_count);
         $display("sim failed");
         $finish;
      end
   end

   task automatic check_value(input string name, input logic [7:0] expected,
                              input logic [7:0] actual, input bit at_least);
      logic ok;
      check_count++;
      ok = at_least ? (actual >= expected) : (actual === expected);
      if (!ok) begin
         error_count++;
         $display("** Error: %s expected %s%h, actual %h", name,
                  at_least ? ">= " : "", expected, actual);
      end
   endtask

   // DMA source byte built from the whole address
   function automatic logic [7:0] fill_byte(input logic [15:0] a);
      return {a[3:0], a[7:4]} ^ a[15:8] ^ 8'h5a;
   endfunction

   task automatic add_test(input string name, input int op, input logic [15:0] a,
                           input logic [7:0] d, input logic [7:0] expected);
      t_name.push_back(name);
      t_op.push_back(op);
      t_addr.push_back(a);
      t_wdata.push_back(d);
      t_exp.push_back(expected);
   endtask

   task automatic build_table();
      logic [31:0] rnd;
      logic [15:0] a;
      logic [7:0]  d;
      logic [15:0] holes [3];
      string       n;
      holes = '{16'h0000, 16'h8000, 16'hff50};
      // work RAM ends and random addresses in between
      for (int i = 0; i < 8; i++) begin
         rnd = $random(seed);
         a   = (i == 0) ? 16'hc000 : (i == 1) ? 16'hdfff : (16'hc000 | {3'b0, rnd[12:0]});
         rnd = $random(seed);
         d   = rnd[7:0];
         n   = $sformatf("wram_%0d", i);
         add_test(n, op_write, a, d, 8'h00);
         add_test(n, op_read, a, 8'h00, d);
      end
      for (int i = 0; i < 3; i++) begin
         n = $sformatf("unmapped_%h", holes[i]);
         add_test(n, op_write, holes[i], 8'ha5, 8'h00);
         add_test(n, op_read, holes[i], 8'h00, 8'h00);
      end
      // source page C1 for the DMA copy
      for (int i = 0; i < `GB_DMA_LEN; i++) begin
         a = 16'hc100 | 16'(i);
         add_test("dma_fill", op_write, a, fill_byte(a), 8'h00);
      end
      add_test("dma_start", op_write, `GB_MMIO_DMA, 8'hc1, 8'h00);
      add_test("read_during_dma", op_read, 16'hc100, 8'h00, fill_byte(16'hc100));
      for (int i = 0; i < `GB_DMA_LEN; i++) begin
         a = 16'hfe00 | 16'(i);
         add_test($sformatf("oam_%h", a), op_read, a, 8'h00, fill_byte(16'hc100 | 16'(i)));
      end
      // TAC keeps only bits 2:0 and the timer stays stopped
      add_test("tac_low_bits", op_write, `GB_MMIO_TAC, 8'hfb, 8'h00);
      add_test("tac_low_bits", op_read, `GB_MMIO_TAC, 8'h00, 8'hfb & 8'h07);
      add_test("tac_off", op_write, `GB_MMIO_TAC, 8'hf8, 8'h00);
      add_test("tac_off", op_read, `GB_MMIO_TAC, 8'h00, 8'h00);
      rnd = $random(seed);
      add_test("tima_rw", op_write, `GB_MMIO_TIMA, rnd[7:0], 8'h00);
      add_test("tima_rw", op_read, `GB_MMIO_TIMA, 8'h00, rnd[7:0]);
      add_test("tma_rw", op_write, `GB_MMIO_TMA, rnd[15:8], 8'h00);
      add_test("tma_rw", op_read, `GB_MMIO_TMA, 8'h00, rnd[15:8]);
      add_test("div_clear", op_write, `GB_MMIO_DIV, rnd[23:16], 8'h00);
      add_test("div_clear", op_read, `GB_MMIO_DIV, 8'h00, 8'h00);
      // overflow at 16 clocks per tick
      add_test("ovf_tma", op_write, `GB_MMIO_TMA, 8'hf0, 8'h00);
      add_test("ovf_tima", op_write, `GB_MMIO_TIMA, 8'hfe, 8'h00);
      add_test("ovf_ie", op_write, `GB_MMIO_IE, 8'h04, 8'h00);
      add_test("ovf_tac", op_write, `GB_MMIO_TAC, 8'h05, 8'h00);
      add_test("ovf_if_poll", op_poll, `GB_MMIO_IF, 8'h00, 8'h04);
      add_test("ovf_irq_high", op_irq, 16'h0000, 8'h00, 8'h01);
      add_test("ovf_tima_reload", op_read_min, `GB_MMIO_TIMA, 8'h00, 8'hf0);
      add_test("if_clear", op_write, `GB_MMIO_IF, 8'h00, 8'h00);
      add_test("if_clear_irq_low", op_irq, 16'h0000, 8'h00, 8'h00);
      add_test("timer_stop", op_write, `GB_MMIO_TAC, 8'h00, 8'h00);
   endtask

   task automatic axi_write(input string name, input logic [15:0] a, input logic [7:0] d);
      @(posedge clock);
      awvalid <= 1'b1;
      awaddr  <= a;
      wvalid  <= 1'b1;
      wdata   <= {24'h0, d};
      wstrb   <= 4'h1;
      bready  <= 1'b1;
      @(posedge clock);
      while (!(awready && wready)) @(posedge clock);
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      @(posedge clock);
      while (!bvalid) @(posedge clock);
      bready <= 1'b0;
      check_value({name, " bresp"}, 8'h00, {6'b0, bresp}, 1'b0);
   endtask

   task automatic axi_read(input string name, input logic [15:0] a, output logic [7:0] d);
      @(posedge clock);
      arvalid <= 1'b1;
      araddr  <= a;
      rready  <= 1'b1;
      @(posedge clock);
      while (!arready) @(posedge clock);
      arvalid <= 1'b0;
      @(posedge clock);
      while (!rvalid) @(posedge clock);
      d = rdata[7:0];
      rready <= 1'b0;
      check_value({name, " rresp"}, 8'h00, {6'b0, rresp}, 1'b0);
   endtask

   task automatic run_test(input int i);
      logic [7:0] got;
      int         start;
      case (t_op[i])
         op_write: axi_write(t_name[i], t_addr[i], t_wdata[i]);
         op_read, op_read_min: begin
            axi_read(t_name[i], t_addr[i], got);
            check_value(t_name[i], t_exp[i], got, t_op[i] == op_read_min);
         end
         op_poll: begin
            start = cycles;
            got   = 8'h00;
            while ((got & t_exp[i]) == 8'h00 && cycles - start <= 200) begin
               axi_read(t_name[i], t_addr[i], got);
            end
            check_value(t_name[i], t_exp[i], got & t_exp[i], 1'b0);
         end
         default: begin
            @(posedge clock);
            check_value(t_name[i], t_exp[i], {7'b0, irq}, 1'b0);
         end
      endcase
   endtask

   initial begin
      clock   = 1'b0;
      reset   = 1'b1;
      awvalid = 1'b0;
      awaddr  = '0;
      wvalid  = 1'b0;
      wdata   = '0;
      wstrb   = '0;
      bready  = 1'b0;
      arvalid = 1'b0;
      araddr  = '0;
      rready  = 1'b0;
      seed    = 32'he261_15ec;
      build_table();
      cycle_limit = t_op.size() * 400 + 2000;
      repeat (5) @(posedge clock);
      reset <= 1'b0;
      @(posedge clock);
      for (int i = 0; i < t_op.size(); i++) begin
         run_test(i);
      end
      repeat (2) @(posedge clock);
      $display("errors: %0d of %0d checks", error_count, check_count);
      if (error_count == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+source
source/gb_bus_pkg.sv
source/axi_lite_host_port.sv
source/bus_arbiter.sv
source/oam_dma.sv
source/timer_unit.sv
source/bus_memories.sv
source/gb_mmio.sv
testbench/tb_gb_mmio.sv
